/* logic/bp_types.sv */
`default_nettype none

package bp_types;

    import rv32i_types::*;

    // direction table size.
    localparam int dir_entries    = 32;
    localparam int dir_index_bits = 5;

    // target buffer size; index is pc[5:2], tag is pc[31:6].
    localparam int btb_entries    = 16;
    localparam int btb_index_bits = 4;

    // two-bit saturating direction state.
    typedef enum logic [1:0]
    {
        strong_taken     = 2'b00,
        weak_taken       = 2'b01,
        weak_not_taken   = 2'b10,
        strong_not_taken = 2'b11
    } pred_state_t;

    // lookup request from the fetch stage.
    typedef struct packed
    {
        logic      valid; // a fetch happens this cycle.
        rv32i_word pc;
    } fetch_query_t;

    // outcome of one branch from execute.
    typedef struct packed
    {
        logic      valid;
        rv32i_word pc;
        logic      taken;
        rv32i_word target;
        logic      correct; // earlier prediction matched the outcome.
    } resolve_t;

endpackage

`default_nettype wire

/* logic/branch_predict_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_predict_unit
    import rv32i_types::*, bp_types::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      stall,
    input  resolve_t  resolve,
    output rv32i_word fetch_pc,
    output logic      pred_taken
);

    fetch_query_t query;
    logic         dir_taken;
    logic         btb_hit;
    rv32i_word    btb_target;

    fetch_pc_unit fetch_pc_unit
    (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .resolve    (resolve),
        .dir_taken  (dir_taken),
        .btb_hit    (btb_hit),
        .btb_target (btb_target),
        .query      (query),
        .pred_taken (pred_taken)
    );

    direction_predictor direction_predictor
    (
        .clk       (clk),
        .rst       (rst),
        .query     (query),
        .resolve   (resolve),
        .dir_taken (dir_taken)
    );

    target_buffer target_buffer
    (
        .clk        (clk),
        .rst        (rst),
        .query      (query),
        .resolve    (resolve),
        .btb_hit    (btb_hit),
        .btb_target (btb_target)
    );

    assign fetch_pc = query.pc;

endmodule

`default_nettype wire

/* logic/direction_predictor.sv */
`timescale 1ns/1ps
`default_nettype none

module direction_predictor
    import bp_types::*;
(
    input  logic         clk,
    input  logic         rst,
    input  fetch_query_t query,
    input  resolve_t     resolve,
    output logic         dir_taken
);

    logic [dir_entries-1:0]    used;
    logic [31:2]               tags [dir_entries];
    pred_state_t               states [dir_entries];
    logic [dir_index_bits-1:0] ptr; // next slot to allocate.

    logic [dir_entries-1:0]    fetch_match;
    logic [dir_entries-1:0]    res_match;
    logic [dir_index_bits-1:0] fetch_idx;
    logic [dir_index_bits-1:0] res_idx;
    logic                      fetch_hit;
    logic                      res_hit;
    logic                      alloc_req;
    logic                      do_alloc;
    logic                      do_correct;

    function automatic logic [dir_entries-1:0] match_vec(input logic [31:2] key);
        logic [dir_entries-1:0] vec;
        vec = '0;
        for (int i = 0; i < dir_entries; i++)
        begin
            vec[i] = used[i] && (tags[i] == key);
        end
        return vec;
    endfunction

    function automatic logic [dir_index_bits-1:0] encode(input logic [dir_entries-1:0] vec);
        logic [dir_index_bits-1:0] idx;
        idx = '0;
        for (int i = 0; i < dir_entries; i++)
        begin
            if (vec[i])
            begin
                idx = dir_index_bits'(i);
            end
        end
        return idx;
    endfunction

    // correct strengthens, a miss moves one step toward the other side.
    function automatic pred_state_t next_state(input pred_state_t cur, input logic correct);
        unique case (cur)
            strong_taken:   return correct ? strong_taken : weak_taken;
            weak_taken:     return correct ? strong_taken : weak_not_taken;
            weak_not_taken: return correct ? strong_not_taken : weak_taken;
            default:        return correct ? strong_not_taken : weak_not_taken;
        endcase
    endfunction

    always_comb
    begin
        fetch_match = match_vec(query.pc[31:2]);
        res_match   = match_vec(resolve.pc[31:2]);
        fetch_idx   = encode(fetch_match);
        res_idx     = encode(res_match);
        fetch_hit   = |fetch_match;
        res_hit     = |res_match;
    end

    // allocation into the slot being corrected wins, else correction wins.
    assign alloc_req  = query.valid && !fetch_hit;
    assign do_correct = resolve.valid && res_hit && !(alloc_req && (res_idx == ptr));
    assign do_alloc   = alloc_req && !do_correct;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            used <= '0;
            ptr  <= '0;
            for (int i = 0; i < dir_entries; i++)
            begin
                states[i] <= weak_not_taken;
            end
        end
        else if (do_correct)
        begin
            states[res_idx] <= next_state(states[res_idx], resolve.correct);
        end
        else if (do_alloc)
        begin
            used[ptr]   <= 1'b1;
            states[ptr] <= weak_not_taken;
            ptr         <= ptr + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_alloc)
        begin
            tags[ptr] <= query.pc[31:2];
        end
    end

    assign dir_taken = fetch_hit &&
                       ((states[fetch_idx] == strong_taken) || (states[fetch_idx] == weak_taken));

    // no pc is ever held in two slots.
    a_fetch_unique: assert property (@(posedge clk) disable iff (rst) $onehot0(fetch_match));
    a_res_unique: assert property (@(posedge clk) disable iff (rst) $onehot0(res_match));

    // the pointer only moves after a valid fetch that missed.
    a_ptr_alloc_only: assert property (@(posedge clk) disable iff (rst)
        !(query.valid && !fetch_hit) |=> $stable(ptr));

endmodule

`default_nettype wire

/* logic/fetch_pc_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_pc_unit
    import rv32i_types::*, bp_types::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         stall,
    input  resolve_t     resolve,
    input  logic         dir_taken,
    input  logic         btb_hit,
    input  rv32i_word    btb_target,
    output fetch_query_t query,
    output logic         pred_taken
);

    rv32i_word pc_q;
    rv32i_word pc_next;
    logic      redirect;

    assign redirect = resolve.valid && !resolve.correct;

    // a prediction needs both a taken direction and a known target.
    assign pred_taken = query.valid && dir_taken && btb_hit;

    always_comb
    begin
        if (redirect) // overrides stall.
        begin
            pc_next = resolve.taken ? resolve.target : resolve.pc + inst_bytes;
        end
        else if (stall)
        begin
            pc_next = pc_q;
        end
        else if (pred_taken)
        begin
            pc_next = btb_target;
        end
        else
        begin
            pc_next = pc_q + inst_bytes;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc_q <= reset_vector;
        end
        else
        begin
            pc_q <= pc_next;
        end
    end

    always_comb
    begin
        query.valid = !stall;
        query.pc    = pc_q;
    end

    // targets come from execute and the btb, both must keep alignment.
    a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc_q[1:0] == 2'b00);

endmodule

`default_nettype wire

/* logic/rv32i_types.sv */
`default_nettype none

package rv32i_types;

    // instruction address or data word.
    typedef logic [31:0] rv32i_word;

    // pc loaded when the core leaves reset.
    localparam rv32i_word reset_vector = 32'h0000_0000;

    // sequential fetch step, one instruction.
    localparam rv32i_word inst_bytes = 32'd4;

endpackage

`default_nettype wire

/* logic/target_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module target_buffer
    import rv32i_types::*, bp_types::*;
(
    input  logic         clk,
    input  logic         rst,
    input  fetch_query_t query,
    input  resolve_t     resolve,
    output logic         btb_hit,
    output rv32i_word    btb_target
);

    logic [btb_entries-1:0]          line_valid;
    logic [31:btb_index_bits+2]      line_tag [btb_entries];
    rv32i_word                       line_target [btb_entries];

    logic [btb_index_bits-1:0]       fetch_idx;
    logic [btb_index_bits-1:0]       res_idx;
    logic                            write_en;

    assign fetch_idx = query.pc[btb_index_bits+1:2];
    assign res_idx   = resolve.pc[btb_index_bits+1:2];
    assign write_en  = resolve.valid && resolve.taken; // only taken branches need a target.

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            line_valid <= '0;
        end
        else if (write_en)
        begin
            line_valid[res_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (write_en)
        begin
            line_tag[res_idx]    <= resolve.pc[31:btb_index_bits+2];
            line_target[res_idx] <= resolve.target;
        end
    end

    // direct mapped, so one compare at the indexed line.
    always_comb
    begin
        btb_hit    = line_valid[fetch_idx] &&
                     (line_tag[fetch_idx] == query.pc[31:btb_index_bits+2]);
        btb_target = line_target[fetch_idx];
    end

    // a buffer just out of reset holds nothing.
    a_no_hit_after_reset: assert property (@(posedge clk) rst |=> !btb_hit);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module branch_predict_unit_tb \
    -f sources.f \
    -o sim_branch_predict

./obj_dir/sim_branch_predict > sim.log 2>&1 || true
cat sim.log

if grep -q "Errors found" sim.log; then
    exit 1
fi
if ! grep -q "No errors" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0

/* sources.f */
logic/rv32i_types.sv
logic/bp_types.sv
logic/direction_predictor.sv
logic/target_buffer.sv
logic/fetch_pc_unit.sv
logic/branch_predict_unit.sv
tests/branch_predict_unit_tb.sv

/* tests/branch_predict_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_predict_unit_tb
    import rv32i_types::*, bp_types::*;
();

    localparam int clk_period      = 100;
    localparam int directed_cycles = 160;
    localparam int random_cycles   = 400;
    localparam int margin_cycles   = 100;

    localparam rv32i_word jump_src   = 32'h0000_0f3c; // btb line 15 stays clear of the test branches.
    localparam rv32i_word walk_pc    = 32'h0000_0100;
    localparam rv32i_word walk_dest  = 32'h0000_0180;
    localparam rv32i_word evict_pc   = 32'h0000_1000;
    localparam rv32i_word evict_dest = 32'h0000_2000;

    logic      clk;
    logic      rst;
    logic      stall;
    resolve_t  resolve;
    rv32i_word fetch_pc;
    logic      pred_taken;

    // reference copies of both tables and the fetch pc.
    logic [dir_entries-1:0]     m_used;
    logic [31:2]                m_tag [dir_entries];
    pred_state_t                m_state [dir_entries];
    int                         m_ptr;
    logic [btb_entries-1:0]     b_valid;
    logic [31:btb_index_bits+2] b_tag [btb_entries];
    rv32i_word                  b_target [btb_entries];
    rv32i_word                  exp_pc = reset_vector;
    logic                       exp_pred;

    integer seed        = 32'hcbe0;
    int     error_count = 0;

    // {correct, taken} pairs that walk walk_pc through every state.
    logic [1:0] walk_steps [7] = '{2'b01, 2'b11, 2'b00, 2'b00, 2'b10, 2'b00, 2'b01};

    branch_predict_unit UUT
    (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .resolve    (resolve),
        .fetch_pc   (fetch_pc),
        .pred_taken (pred_taken)
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic int find_dir(input rv32i_word pc);
        int idx;
        idx = -1;
        for (int i = 0; i < dir_entries; i++)
        begin
            if (m_used[i] && (m_tag[i] == pc[31:2]))
            begin
                idx = i;
            end
        end
        return idx;
    endfunction

    function automatic logic predict(input rv32i_word pc, input logic stl);
        int   idx;
        logic btb;
        idx = find_dir(pc);
        btb = b_valid[pc[btb_index_bits+1:2]] &&
              (b_tag[pc[btb_index_bits+1:2]] == pc[31:btb_index_bits+2]);
        if (stl || (idx < 0))
        begin
            return 1'b0;
        end
        return btb && ((m_state[idx] == strong_taken) || (m_state[idx] == weak_taken));
    endfunction

    function automatic pred_state_t step_state(input pred_state_t s, input logic correct);
        if (correct)
        begin
            return ((s == strong_taken) || (s == weak_taken)) ? strong_taken : strong_not_taken;
        end
        case (s)
            strong_taken:   return weak_taken;
            weak_taken:     return weak_not_taken;
            weak_not_taken: return weak_taken;
            default:        return weak_not_taken;
        endcase
    endfunction

    function automatic resolve_t make_res(input rv32i_word pc, input logic taken,
                                          input rv32i_word target, input logic correct);
        resolve_t r;
        r.valid   = 1'b1;
        r.pc      = pc;
        r.taken   = taken;
        r.target  = target;
        r.correct = correct;
        return r;
    endfunction

    always @(posedge clk)
    begin : reference_model
        int        f_idx;
        int        r_idx;
        logic      alloc;
        rv32i_word next_pc;
        f_idx = find_dir(exp_pc);
        r_idx = resolve.valid ? find_dir(resolve.pc) : -1;
        alloc = !stall && (f_idx < 0);
        if (resolve.valid && !resolve.correct)
            next_pc = resolve.taken ? resolve.target : resolve.pc + inst_bytes;
        else if (stall)
            next_pc = exp_pc;
        else if (exp_pred)
            next_pc = b_target[exp_pc[btb_index_bits+1:2]]; // read before this edge's write.
        else
            next_pc = exp_pc + inst_bytes;
        if (rst)
        begin
            m_used  = '0;
            m_ptr   = 0;
            b_valid = '0;
            exp_pc <= reset_vector;
        end
        else
        begin
            if ((r_idx >= 0) && !(alloc && (r_idx == m_ptr)))
            begin
                m_state[r_idx] = step_state(m_state[r_idx], resolve.correct);
            end
            else if (alloc)
            begin
                m_used[m_ptr]  = 1'b1;
                m_tag[m_ptr]   = exp_pc[31:2];
                m_state[m_ptr] = weak_not_taken;
                m_ptr          = (m_ptr + 1) % dir_entries;
            end
            if (resolve.valid && resolve.taken)
            begin
                b_valid[resolve.pc[btb_index_bits+1:2]]  = 1'b1;
                b_tag[resolve.pc[btb_index_bits+1:2]]    = resolve.pc[31:btb_index_bits+2];
                b_target[resolve.pc[btb_index_bits+1:2]] = resolve.target;
            end
            exp_pc <= next_pc;
        end
    end

    task automatic report_mismatch(input string name, input rv32i_word expected,
                                   input rv32i_word actual);
        error_count++;
        $display("[ERROR] %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
        $display("Errors found");
        $fatal(1, "output differs from the reference model");
    endtask

    a_fetch_pc: assert property (@(posedge clk) disable iff (rst) fetch_pc == exp_pc)
        else report_mismatch("fetch_pc", $sampled(exp_pc), $sampled(fetch_pc));
    a_pred_taken: assert property (@(posedge clk) disable iff (rst) pred_taken == exp_pred)
        else report_mismatch("pred_taken", 32'($sampled(exp_pred)), 32'($sampled(pred_taken)));

    task automatic apply_inputs(input logic stl, input resolve_t res);
        stall    = stl;
        resolve  = res;
        exp_pred = predict(exp_pc, stl); // model state has settled since the edge.
    endtask

    task automatic run_cycle(input logic stl, input resolve_t res);
        @(posedge clk);
        #5;
        apply_inputs(stl, res);
    endtask

    task automatic idle(input int n);
        repeat (n) run_cycle(1'b0, '0);
    endtask

    task automatic hold_stall(input int n);
        repeat (n) run_cycle(1'b1, '0);
    endtask

    // one-cycle resolve strobe, then the strobe drops.
    task automatic pulse_resolve(input logic stl, input resolve_t res);
        run_cycle(stl, res);
        run_cycle(stl, '0);
    endtask

    task automatic jump_to(input rv32i_word pc);
        pulse_resolve(1'b0, make_res(jump_src, 1'b1, pc, 1'b0));
    endtask

    initial
    begin
        logic [31:0] r;
        resolve_t    rnd_res;
        clk      = 1'b0;
        rst      = 1'b1;
        stall    = 1'b0;
        resolve  = '0;
        exp_pred = 1'b0;
        repeat (2) @(posedge clk);
        #5;
        rst = 1'b0;
        apply_inputs(1'b0, '0);

        idle(8);
        hold_stall(4);
        idle(2);
        // redirect to a fresh pc under stall; its first fetch comes after the stall.
        pulse_resolve(1'b1, make_res(jump_src, 1'b1, 32'h0000_0400, 1'b0));
        // the stalled pc holds no entry, so resolving it onto itself must not train it.
        pulse_resolve(1'b1, make_res(32'h0000_0400, 1'b1, 32'h0000_0400, 1'b0));
        hold_stall(3);
        idle(2);

        for (int i = 0; i < 7; i++)
        begin
            jump_to(walk_pc);
            pulse_resolve(1'b0, make_res(walk_pc, walk_steps[i][0], walk_dest, walk_steps[i][1]));
            idle(3);
        end
        jump_to(walk_pc);
        idle(3);

        pulse_resolve(1'b1, make_res(32'h0000_0340, 1'b1, 32'h0000_0600, 1'b0));
        pulse_resolve(1'b1, make_res(32'h0000_0600, 1'b0, 32'h0000_0900, 1'b0));
        idle(2);

        // evict_pc becomes weak taken, then 33 new pcs push it out.
        jump_to(evict_pc);
        pulse_resolve(1'b0, make_res(evict_pc, 1'b1, evict_dest, 1'b0));
        idle(dir_entries + 2);
        jump_to(evict_pc);
        idle(3);

        for (int i = 0; i < random_cycles; i++)
        begin
            r = $random(seed);
            if (r[4:3] == 2'b00)
                rnd_res = make_res({24'h0, r[12:7], 2'b00}, r[5], {24'h0, r[18:13], 2'b00}, r[6]);
            else
                rnd_res = '0;
            run_cycle(r[2:0] == 3'd0, rnd_res);
        end
        idle(2);

        if (error_count == 0)
        begin
            $display("No errors");
            $finish;
        end
        else
        begin
            $display("Errors found");
            $fatal(1, "reference model mismatch");
        end
    end

    initial
    begin
        #((directed_cycles + random_cycles + margin_cycles) * clk_period);
        $display("watchdog timeout, the test sequence did not complete");
        $display("Errors found");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire
